// File: logic/matmul_types_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// data widths and memory layout for the 2x2 matrix multiplier
////////////////////////////////////////////////////////////////////////////

package matmul_types_pkg;

    localparam int ELEM_W   = 2;                 // unsigned element
    localparam int PROD_W   = 2 * ELEM_W;        // one element product
    localparam int RESULT_W = PROD_W + 1;        // max 3*3 + 3*3 = 18

    typedef logic [ELEM_W-1:0]   elem_t;
    typedef logic [PROD_W-1:0]   prod_t;
    typedef logic [RESULT_W-1:0] result_t;

    // element store, A in the low half and B in the high half
    localparam int ELEM_COUNT = 8;
    localparam int MEM_ADDR_W = $clog2(ELEM_COUNT);
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    localparam int A_BASE = 0;
    localparam int B_BASE = 4;

    localparam int SWITCH_W = ELEM_COUNT * ELEM_W;   // 16 switches

    // operand registers: A first, A second, B first, B second
    localparam int OPERAND_COUNT = 4;
    typedef logic [$clog2(OPERAND_COUNT)-1:0] slot_t;

    // element idx sits at bit pair idx counted from the top
    // so A11 is switches[15:14] and B22 is switches[1:0]
    function automatic elem_t switch_elem(input logic [SWITCH_W-1:0] sw,
                                          input mem_addr_t idx);
        return sw[SWITCH_W - 1 - ELEM_W * idx -: ELEM_W];
    endfunction

endpackage

`default_nettype wire

// File: logic/matmul_seq_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// product sequencer states and operand schedule
////////////////////////////////////////////////////////////////////////////

package matmul_seq_pkg;

    typedef enum logic [3:0] {
        S_IDLE,
        S_READ_FIRST,      // address of A-row-first
        S_LOAD_READ_1,     // load slot 0, read A-row-second
        S_LOAD_READ_2,     // load slot 1, read B-col-first
        S_LOAD_READ_3,     // load slot 2, read B-col-second
        S_LOAD_LAST,       // load slot 3
        S_MULTIPLY,
        S_ADD,
        S_LATCH,
        S_ADVANCE,
        S_DONE
    } seq_state_t;

    localparam int RESULT_COUNT = 4;             // C11, C12, C21, C22
    typedef logic [$clog2(RESULT_COUNT)-1:0] iter_t;

    // per result: a_i1, a_i2, b_1j, b_2j
    localparam matmul_types_pkg::mem_addr_t
        OPERAND_ADDR [RESULT_COUNT][matmul_types_pkg::OPERAND_COUNT] = '{
        '{3'(matmul_types_pkg::A_BASE + 0), 3'(matmul_types_pkg::A_BASE + 1),
          3'(matmul_types_pkg::B_BASE + 0), 3'(matmul_types_pkg::B_BASE + 2)},
        '{3'(matmul_types_pkg::A_BASE + 0), 3'(matmul_types_pkg::A_BASE + 1),
          3'(matmul_types_pkg::B_BASE + 1), 3'(matmul_types_pkg::B_BASE + 3)},
        '{3'(matmul_types_pkg::A_BASE + 2), 3'(matmul_types_pkg::A_BASE + 3),
          3'(matmul_types_pkg::B_BASE + 0), 3'(matmul_types_pkg::B_BASE + 2)},
        '{3'(matmul_types_pkg::A_BASE + 2), 3'(matmul_types_pkg::A_BASE + 3),
          3'(matmul_types_pkg::B_BASE + 1), 3'(matmul_types_pkg::B_BASE + 3)}
    };

endpackage

`default_nettype wire

// File: logic/mac_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// control from the product sequencer into the MAC unit
interface mac_ctrl_if;

    logic                        operand_load;   // store rd_data this edge
    matmul_types_pkg::slot_t     operand_slot;
    logic                        acc_en;         // add both products
    logic                        acc_clear;      // beats acc_en
    matmul_types_pkg::result_t   acc_sum;

    modport sequencer (
        output operand_load,
        output operand_slot,
        output acc_en,
        output acc_clear,
        input  acc_sum
    );

    modport mac (
        input  operand_load,
        input  operand_slot,
        input  acc_en,
        input  acc_clear,
        output acc_sum
    );

endinterface

`default_nettype wire

// File: logic/matrix_loader.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_loader (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic                                    load,
    input  wire logic [matmul_types_pkg::SWITCH_W-1:0]   switches,
    output logic                                         wr_en,
    output matmul_types_pkg::mem_addr_t                  wr_addr,
    output matmul_types_pkg::elem_t                      wr_data,
    output logic                                         load_done
);

    logic                                  busy;
    matmul_types_pkg::mem_addr_t           count;     // element being written
    logic [matmul_types_pkg::SWITCH_W-1:0] sw_q;      // switch word held for the burst

    ////////////////////////////////////////////////////////////////////////
    // burst control
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            count     <= '0;
            load_done <= 1'b0;
        end else if (busy) begin
            count <= count + 1'b1;
            // last element goes out this cycle
            if (count == matmul_types_pkg::mem_addr_t'(matmul_types_pkg::ELEM_COUNT - 1)) begin
                busy      <= 1'b0;
                load_done <= 1'b1;   // sticky until reset
            end
        end else if (load && !load_done) begin
            busy  <= 1'b1;
            count <= '0;
        end
    end

    // capture the word at the strobe
    always_ff @(posedge clk) begin
        if (load && !busy && !load_done) begin
            sw_q <= switches;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////

    assign wr_en   = busy;
    assign wr_addr = count;   // element k lands at address k
    assign wr_data = matmul_types_pkg::switch_elem(sw_q, count);

endmodule

`default_nettype wire

// File: logic/element_ram.sv
`timescale 1ns/1ps
`default_nettype none

module element_ram (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          wr_en,
    input  wire matmul_types_pkg::mem_addr_t   wr_addr,
    input  wire matmul_types_pkg::elem_t       wr_data,
    input  wire matmul_types_pkg::mem_addr_t   rd_addr,
    output matmul_types_pkg::elem_t            rd_data
);

    // A11..A22 at 0..3, B11..B22 at 4..7
    matmul_types_pkg::elem_t mem [matmul_types_pkg::ELEM_COUNT];

    // write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < matmul_types_pkg::ELEM_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: logic/mac_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire matmul_types_pkg::elem_t   rd_data,
    mac_ctrl_if.mac                        ctrl
);

    // slot 0 a_i1, slot 1 a_i2, slot 2 b_1j, slot 3 b_2j
    matmul_types_pkg::elem_t   operand [matmul_types_pkg::OPERAND_COUNT];

    matmul_types_pkg::prod_t   prod_first;    // a_i1 * b_1j
    matmul_types_pkg::prod_t   prod_second;   // a_i2 * b_2j
    matmul_types_pkg::result_t acc;

    ////////////////////////////////////////////////////////////////////////
    // operand registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < matmul_types_pkg::OPERAND_COUNT; i++) begin
                operand[i] <= '0;
            end
        end else if (ctrl.operand_load) begin
            operand[ctrl.operand_slot] <= rd_data;   // memory data of this cycle
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // multipliers and accumulator
    ////////////////////////////////////////////////////////////////////////

    // widen first so the products keep all four bits
    assign prod_first  = matmul_types_pkg::prod_t'(operand[0])
                       * matmul_types_pkg::prod_t'(operand[2]);
    assign prod_second = matmul_types_pkg::prod_t'(operand[1])
                       * matmul_types_pkg::prod_t'(operand[3]);

    always_ff @(posedge clk) begin
        if (rst || ctrl.acc_clear) begin
            acc <= '0;   // clear wins over enable
        end else if (ctrl.acc_en) begin
            acc <= acc
                 + matmul_types_pkg::result_t'(prod_first)
                 + matmul_types_pkg::result_t'(prod_second);
        end
    end

    assign ctrl.acc_sum = acc;

endmodule

`default_nettype wire

// File: logic/product_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module product_sequencer (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire logic                      load_done,
    output matmul_types_pkg::mem_addr_t    rd_addr,
    mac_ctrl_if.sequencer                  ctrl,
    output matmul_types_pkg::result_t      c11,
    output matmul_types_pkg::result_t      c12,
    output matmul_types_pkg::result_t      c21,
    output matmul_types_pkg::result_t      c22,
    output logic                           calc_done
);

    matmul_seq_pkg::seq_state_t state;
    matmul_seq_pkg::seq_state_t state_next;
    matmul_seq_pkg::iter_t      iter;      // index of the result being formed
    logic                       last_iter;

    assign last_iter =
        (iter == matmul_seq_pkg::iter_t'(matmul_seq_pkg::RESULT_COUNT - 1));

    ////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= matmul_seq_pkg::S_IDLE;
            iter  <= '0;
        end else begin
            state <= state_next;
            if (state == matmul_seq_pkg::S_ADVANCE) begin
                iter <= iter + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            matmul_seq_pkg::S_IDLE: begin
                if (start && load_done) begin   // no run before the matrices are in
                    state_next = matmul_seq_pkg::S_READ_FIRST;
                end
            end
            matmul_seq_pkg::S_READ_FIRST:  state_next = matmul_seq_pkg::S_LOAD_READ_1;
            matmul_seq_pkg::S_LOAD_READ_1: state_next = matmul_seq_pkg::S_LOAD_READ_2;
            matmul_seq_pkg::S_LOAD_READ_2: state_next = matmul_seq_pkg::S_LOAD_READ_3;
            matmul_seq_pkg::S_LOAD_READ_3: state_next = matmul_seq_pkg::S_LOAD_LAST;
            matmul_seq_pkg::S_LOAD_LAST:   state_next = matmul_seq_pkg::S_MULTIPLY;
            matmul_seq_pkg::S_MULTIPLY:    state_next = matmul_seq_pkg::S_ADD;
            matmul_seq_pkg::S_ADD:         state_next = matmul_seq_pkg::S_LATCH;
            matmul_seq_pkg::S_LATCH:       state_next = matmul_seq_pkg::S_ADVANCE;
            matmul_seq_pkg::S_ADVANCE: begin
                state_next = last_iter ? matmul_seq_pkg::S_DONE
                                       : matmul_seq_pkg::S_READ_FIRST;
            end
            matmul_seq_pkg::S_DONE:        state_next = matmul_seq_pkg::S_DONE;
            default:                       state_next = matmul_seq_pkg::S_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // memory reads and MAC control
    ////////////////////////////////////////////////////////////////////////

    // each operand is loaded the cycle after its read
    always_comb begin
        rd_addr           = '0;
        ctrl.operand_load = 1'b0;
        ctrl.operand_slot = '0;
        ctrl.acc_en       = 1'b0;
        ctrl.acc_clear    = 1'b0;
        case (state)
            matmul_seq_pkg::S_READ_FIRST: begin
                rd_addr = matmul_seq_pkg::OPERAND_ADDR[iter][0];
            end
            matmul_seq_pkg::S_LOAD_READ_1: begin
                ctrl.operand_load = 1'b1;
                ctrl.operand_slot = matmul_types_pkg::slot_t'(0);
                rd_addr           = matmul_seq_pkg::OPERAND_ADDR[iter][1];
            end
            matmul_seq_pkg::S_LOAD_READ_2: begin
                ctrl.operand_load = 1'b1;
                ctrl.operand_slot = matmul_types_pkg::slot_t'(1);
                rd_addr           = matmul_seq_pkg::OPERAND_ADDR[iter][2];
            end
            matmul_seq_pkg::S_LOAD_READ_3: begin
                ctrl.operand_load = 1'b1;
                ctrl.operand_slot = matmul_types_pkg::slot_t'(2);
                rd_addr           = matmul_seq_pkg::OPERAND_ADDR[iter][3];
            end
            matmul_seq_pkg::S_LOAD_LAST: begin
                ctrl.operand_load = 1'b1;
                ctrl.operand_slot = matmul_types_pkg::slot_t'(3);
            end
            matmul_seq_pkg::S_ADD:     ctrl.acc_en    = 1'b1;
            matmul_seq_pkg::S_ADVANCE: ctrl.acc_clear = 1'b1;   // fresh sum for next result
            default: ;   // multiply just lets the products settle
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // result latching and done flag
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            c11       <= '0;
            c12       <= '0;
            c21       <= '0;
            c22       <= '0;
            calc_done <= 1'b0;
        end else begin
            if (state == matmul_seq_pkg::S_LATCH) begin
                case (iter)
                    2'd0:    c11 <= ctrl.acc_sum;
                    2'd1:    c12 <= ctrl.acc_sum;
                    2'd2:    c21 <= ctrl.acc_sum;
                    default: c22 <= ctrl.acc_sum;
                endcase
            end
            if (state == matmul_seq_pkg::S_ADVANCE && last_iter) begin
                calc_done <= 1'b1;   // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/matmul_top.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_top (
    input  wire logic                                    clk,
    input  wire logic                                    rst,
    input  wire logic                                    load,
    input  wire logic                                    start,
    input  wire logic [matmul_types_pkg::SWITCH_W-1:0]   switches,
    output logic                                         load_done,
    output logic      [matmul_types_pkg::RESULT_W-1:0]   c11,
    output logic      [matmul_types_pkg::RESULT_W-1:0]   c12,
    output logic      [matmul_types_pkg::RESULT_W-1:0]   c21,
    output logic      [matmul_types_pkg::RESULT_W-1:0]   c22,
    output logic                                         calc_done
);

    // loader to memory
    logic                        wr_en;
    matmul_types_pkg::mem_addr_t wr_addr;
    matmul_types_pkg::elem_t     wr_data;

    // sequencer read path into the MAC
    matmul_types_pkg::mem_addr_t rd_addr;
    matmul_types_pkg::elem_t     rd_data;

    mac_ctrl_if i_mac_ctrl ();

    matrix_loader i_matrix_loader (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .switches  (switches),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .load_done (load_done)
    );

    element_ram i_element_ram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    product_sequencer i_product_sequencer (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .load_done (load_done),
        .rd_addr   (rd_addr),
        .ctrl      (i_mac_ctrl.sequencer),
        .c11       (c11),
        .c12       (c12),
        .c21       (c21),
        .c22       (c22),
        .calc_done (calc_done)
    );

    mac_unit i_mac_unit (
        .clk     (clk),
        .rst     (rst),
        .rd_data (rd_data),
        .ctrl    (i_mac_ctrl.mac)
    );

endmodule

`default_nettype wire

// File: testbench/matmul_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_assertions (
    input wire logic                                  clk,
    input wire logic                                  rst,
    input wire logic                                  load_done,
    input wire logic                                  calc_done,
    input wire logic [matmul_types_pkg::RESULT_W-1:0] c11,
    input wire logic [matmul_types_pkg::RESULT_W-1:0] c12,
    input wire logic [matmul_types_pkg::RESULT_W-1:0] c21,
    input wire logic [matmul_types_pkg::RESULT_W-1:0] c22
);

    ////////////////////////////////////////////////////////////////////////////
    // load and done protocol
    ////////////////////////////////////////////////////////////////////////////

    a_load_done_sticky: assert property (
        @(posedge clk) disable iff (rst) $past(load_done) |-> load_done
    ) else $error("load_done fell outside reset");

    a_calc_after_load: assert property (
        @(posedge clk) disable iff (rst) calc_done |-> load_done
    ) else $error("calc_done high while load_done is low");

    a_calc_done_sticky: assert property (
        @(posedge clk) disable iff (rst) $past(calc_done) |-> calc_done
    ) else $error("calc_done fell outside reset");

    // no result may move once the run has finished
    a_results_hold: assert property (
        @(posedge clk) disable iff (rst)
        $past(calc_done) |-> $stable({c11, c12, c21, c22})
    ) else $error("result changed while calc_done is high");

endmodule

bind product_sequencer matmul_assertions i_matmul_assertions (
    .clk       (clk),
    .rst       (rst),
    .load_done (load_done),
    .calc_done (calc_done),
    .c11       (c11),
    .c12       (c12),
    .c21       (c21),
    .c22       (c22)
);

`default_nettype wire

// File: testbench/tb_matmul.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matmul;

    localparam int          PERIOD       = 100;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          RESET_CYCLES = 8;
    localparam int          RUNS         = 20;
    localparam logic [31:0] SEED         = 32'hd8f9709f;
    localparam int          LOAD_LATENCY = 8;        // one write per element
    localparam int          CALC_LATENCY = 4 * 9;    // four results, nine states each
    localparam int          IDLE_WAIT    = 50;
    localparam int          RUN_CYCLES   = 80;       // reset, two loads, compute, late start
    localparam int          TIMEOUT_NS   = 2 * (RUNS * RUN_CYCLES + IDLE_WAIT) * PERIOD;

    logic        clk;
    logic        rst;
    logic        load;
    logic        start;
    logic [15:0] switches;
    logic        load_done;
    logic [4:0]  c11;
    logic [4:0]  c12;
    logic [4:0]  c21;
    logic [4:0]  c22;
    logic        calc_done;

    // expected outputs, kept up to date by the stimulus
    logic        check_en;
    logic        exp_load_done;
    logic        exp_calc_done;
    logic [19:0] exp_results;   // c11 in the top five bits, c22 at the bottom

    matmul_top i_matmul_top (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .start     (start),
        .switches  (switches),
        .load_done (load_done),
        .c11       (c11),
        .c12       (c12),
        .c21       (c21),
        .c22       (c22),
        .calc_done (calc_done)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // c_ij = a_i1 * b_1j + a_i2 * b_2j, elements taken from the top bit pair down
    function automatic logic [19:0] ref_product(input logic [15:0] sw);
        int          a [2][2];
        int          b [2][2];
        logic [19:0] res;
        for (int k = 0; k < 4; k++) begin
            a[k / 2][k % 2] = sw[15 - 2 * k -: 2];
            b[k / 2][k % 2] = sw[7 - 2 * k -: 2];
        end
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                res[19 - 5 * (2 * i + j) -: 5] = 5'(a[i][0] * b[0][j] + a[i][1] * b[1][j]);
            end
        end
        return res;
    endfunction

    task automatic report_failure();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            report_failure();
        end
    endtask

    // outputs only move on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (check_en) begin
            check_value("load_done", exp_load_done, load_done);
            check_value("calc_done", exp_calc_done, calc_done);
            check_value("c11", exp_results[19:15], c11);
            check_value("c12", exp_results[14:10], c12);
            check_value("c21", exp_results[9:5], c21);
            check_value("c22", exp_results[4:0], c22);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_reset();
        check_en = 1'b0;
        rst      = 1'b1;
        load     = 1'b0;
        start    = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        rst           = 1'b0;
        exp_load_done = 1'b0;
        exp_calc_done = 1'b0;
        exp_results   = '0;
        check_en      = 1'b1;   // everything zero right after reset
    endtask

    // edges counted after the one that sampled the strobe
    task automatic measure_latency(input bit calc, input string name, input int latency);
        int cycles;
        cycles = 0;
        while (!(calc ? calc_done : load_done) && cycles < 2 * latency) begin
            next_cycle();
            cycles++;
        end
        if (!(calc ? calc_done : load_done)) begin
            $display("%s never rose within %0d cycles of its strobe", name, 2 * latency);
            report_failure();
        end
        check_value({name, " latency"}, latency, cycles);
    endtask

    task automatic pulse_load(input logic [15:0] word);
        switches = word;
        load     = 1'b1;
        next_cycle();
        load     = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic load_matrices(input logic [15:0] word);
        check_en = 1'b0;
        pulse_load(word);
        measure_latency(1'b0, "load_done", LOAD_LATENCY);
        exp_load_done = 1'b1;
        check_en      = 1'b1;
    endtask

    task automatic run_product(input logic [19:0] expected);
        check_en = 1'b0;
        pulse_start();
        measure_latency(1'b1, "calc_done", CALC_LATENCY);
        exp_calc_done = 1'b1;
        exp_results   = expected;
        check_en      = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] word;
        rst           = 1'b1;
        load          = 1'b0;
        start         = 1'b0;
        switches      = '0;
        check_en      = 1'b0;
        exp_load_done = 1'b0;
        exp_calc_done = 1'b0;
        exp_results   = '0;
        void'($urandom(SEED));
        for (int run = 0; run < RUNS; run++) begin
            word = (run == 0) ? 16'hffff : 16'($urandom());   // all 3s first, 18 everywhere
            apply_reset();
            if (run == 0) begin
                pulse_start();                   // nothing loaded yet
                repeat (IDLE_WAIT) next_cycle();
            end
            load_matrices(word);
            pulse_load(~word);                   // must not overwrite the memory
            repeat (10) next_cycle();
            run_product(ref_product(word));
            repeat (2) next_cycle();
            pulse_start();                       // late start, results must hold
            repeat (10) next_cycle();
        end
        check_en = 1'b0;
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the test sequence finished");
        report_failure();
    end

endmodule

`default_nettype wire

// File: build.f
logic/matmul_types_pkg.sv
logic/matmul_seq_pkg.sv
logic/mac_ctrl_if.sv
logic/matrix_loader.sv
logic/element_ram.sv
logic/mac_unit.sv
logic/product_sequencer.sv
logic/matmul_top.sv
testbench/matmul_assertions.sv
testbench/tb_matmul.sv

// File: Bender.yml
package:
  name: matmul

sources:
  - target: any(rtl, test)
    files:
      - logic/matmul_types_pkg.sv
      - logic/matmul_seq_pkg.sv
      - logic/mac_ctrl_if.sv
      - logic/matrix_loader.sv
      - logic/element_ram.sv
      - logic/mac_unit.sv
      - logic/product_sequencer.sv
      - logic/matmul_top.sv
  - target: test
    files:
      - testbench/matmul_assertions.sv
      - testbench/tb_matmul.sv
